// File: stack_unit.f
logic/stack_pkg.sv
logic/access_timer.sv
logic/stack_ram.sv
logic/reg_file.sv
logic/stack_seq.sv
logic/stack_unit.sv
sim/stack_unit_tb.sv

// File: Makefile
VERILATOR := verilator
TOP       := stack_unit_tb
FILELIST  := stack_unit.f
VFLAGS    := --binary --timing -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
LOG       := sim.log

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/stack_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module stack_unit_tb;

    import stack_pkg::*;

    localparam int wait_cycles = 2;
    localparam int ram_aw      = 8;
    localparam int clk_period  = 40;
    localparam int num_rows    = 36;
    localparam int row_limit   = 24 * (wait_cycles + 2) + 4; // cycles allowed per row

    typedef struct packed {
        cmd_e        op;
        logic [7:0]  post;
        logic        ussel;
        logic [15:0] val;
        logic        rnd;   // load value comes from $random
        logic        poke;  // second cmd_valid while busy
    } row_t;

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    cmd_e        cmd_op;
    postbyte_u   cmd_post;
    logic        cmd_ussel;
    logic [15:0] load_data;
    reg_code_e   rd_sel;
    logic [15:0] rd_data;
    logic        busy;
    logic        done;

    logic [15:0] mreg [0:8];            // model registers by code
    logic [7:0]  mmem [0:2**ram_aw-1];  // model stack image
    string       names [0:9] = '{"a", "b", "x", "y", "s", "u", "dp", "cc", "pc", "code 9"};
    int          errors;
    int          seed;

    stack_unit #(
        .wait_cycles (wait_cycles),
        .ram_aw      (ram_aw)
    ) stack_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_post  (cmd_post),
        .cmd_ussel (cmd_ussel),
        .load_data (load_data),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done)
    );

    function automatic row_t make_row(cmd_e op, logic [7:0] post, logic us,
                                      logic [15:0] val, logic rnd, logic poke);
        return '{op, post, us, val, rnd, poke};
    endfunction

    // post byte is {src, dst} with src unused on load
    function automatic row_t table_row(int i);
        row_t r;
        case (i)
            0:  r = make_row(cmd_load, 8'h00, 1'b0, 16'h0012, 1'b0, 1'b0);
            1:  r = make_row(cmd_load, 8'h01, 1'b0, 16'h0034, 1'b0, 1'b0);
            2:  r = make_row(cmd_load, 8'h02, 1'b0, 16'h1234, 1'b0, 1'b0);
            3:  r = make_row(cmd_load, 8'h03, 1'b0, 16'h5678, 1'b0, 1'b0);
            4:  r = make_row(cmd_load, 8'h04, 1'b0, 16'h0080, 1'b0, 1'b0);
            5:  r = make_row(cmd_load, 8'h05, 1'b0, 16'h00c0, 1'b0, 1'b0);
            6:  r = make_row(cmd_load, 8'h06, 1'b0, 16'hab9c, 1'b0, 1'b0);
            7:  r = make_row(cmd_load, 8'h07, 1'b0, 16'h00d5, 1'b0, 1'b0);
            8:  r = make_row(cmd_load, 8'h08, 1'b0, 16'hc0de, 1'b0, 1'b0);
            9:  r = make_row(cmd_load, 8'h09, 1'b0, 16'hffff, 1'b0, 1'b0);
            10: r = make_row(cmd_load, 8'h0f, 1'b0, 16'heeee, 1'b0, 1'b0);
            11: r = make_row(cmd_load, 8'h00, 1'b0, 16'h0000, 1'b1, 1'b0);
            12: r = make_row(cmd_load, 8'h08, 1'b0, 16'h0000, 1'b1, 1'b0);
            13: r = make_row(cmd_tfr,  8'h02, 1'b0, 16'h0000, 1'b0, 1'b0); // a to x
            14: r = make_row(cmd_tfr,  8'h21, 1'b0, 16'h0000, 1'b0, 1'b0); // x to b
            15: r = make_row(cmd_tfr,  8'h68, 1'b0, 16'h0000, 1'b0, 1'b0); // dp to pc
            16: r = make_row(cmd_tfr,  8'h36, 1'b0, 16'h0000, 1'b0, 1'b0); // y to dp
            17: r = make_row(cmd_tfr,  8'h70, 1'b0, 16'h0000, 1'b0, 1'b0); // cc to a
            18: r = make_row(cmd_push, 8'hff, 1'b0, 16'h0000, 1'b0, 1'b0);
            19: r = make_row(cmd_load, 8'h00, 1'b0, 16'h00ee, 1'b0, 1'b0);
            20: r = make_row(cmd_load, 8'h02, 1'b0, 16'hdead, 1'b0, 1'b0);
            21: r = make_row(cmd_load, 8'h05, 1'b0, 16'h1111, 1'b0, 1'b0);
            22: r = make_row(cmd_load, 8'h07, 1'b0, 16'h0000, 1'b0, 1'b0);
            23: r = make_row(cmd_pull, 8'hff, 1'b0, 16'h0000, 1'b0, 1'b0);
            24: r = make_row(cmd_push, 8'hff, 1'b1, 16'h0000, 1'b0, 1'b1);
            25: r = make_row(cmd_load, 8'h04, 1'b0, 16'h2222, 1'b0, 1'b0);
            26: r = make_row(cmd_load, 8'h03, 1'b0, 16'h0000, 1'b0, 1'b0);
            27: r = make_row(cmd_pull, 8'hff, 1'b1, 16'h0000, 1'b0, 1'b0);
            28: r = make_row(cmd_load, 8'h00, 1'b0, 16'h00a1, 1'b0, 1'b0);
            29: r = make_row(cmd_load, 8'h01, 1'b0, 16'h00b2, 1'b0, 1'b0);
            30: r = make_row(cmd_push, 8'h06, 1'b0, 16'h0000, 1'b0, 1'b0);
            31: r = make_row(cmd_pull, 8'h02, 1'b0, 16'h0000, 1'b0, 1'b0); // gets a back
            32: r = make_row(cmd_pull, 8'h02, 1'b0, 16'h0000, 1'b0, 1'b0); // gets b into a
            33: r = make_row(cmd_push, 8'h00, 1'b0, 16'h0000, 1'b0, 1'b0);
            34: r = make_row(cmd_pull, 8'h00, 1'b1, 16'h0000, 1'b0, 1'b0);
            35: r = make_row(cmd_tfr,  8'h93, 1'b0, 16'h0000, 1'b0, 1'b0); // unused src
            default: r = make_row(cmd_load, 8'h0f, 1'b0, 16'h0000, 1'b0, 1'b0);
        endcase
        return r;
    endfunction

    function automatic logic is_wide(logic [3:0] code);
        return code == reg_x || code == reg_y || code == reg_s || code == reg_u ||
               code == reg_pc;
    endfunction

    // 8-bit registers read with fill in the high byte
    function automatic logic [15:0] model_read(logic [3:0] code, logic fill);
        if (code > 4'd8)
            return 16'h0000;
        if (!is_wide(code))
            return {fill ? 8'hff : 8'h00, mreg[code][7:0]};
        return mreg[code];
    endfunction

    function automatic void model_write(logic [3:0] code, logic [15:0] v);
        if (code <= 4'd8)
            mreg[code] = is_wide(code) ? v : {8'h00, v[7:0]};
    endfunction

    // register code behind each mask bit
    function automatic logic [3:0] mask_code(int i, logic us);
        case (i)
            7:       return reg_pc;
            6:       return us ? reg_s : reg_u;
            5:       return reg_y;
            4:       return reg_x;
            3:       return reg_dp;
            2:       return reg_b;
            1:       return reg_a;
            default: return reg_cc;
        endcase
    endfunction

    // bytes moved for a push or pull set
    function automatic int byte_count(logic [7:0] mask);
        int cnt;
        cnt = 0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i])
                cnt += is_wide(mask_code(i, 1'b0)) ? 2 : 1;
        end
        return cnt;
    endfunction

    task automatic model_push(logic [7:0] mask, logic us);
        logic [3:0]  sp_code;
        logic [3:0]  code;
        logic [15:0] ptr;
        logic [15:0] v;
        sp_code = us ? reg_u : reg_s;
        ptr = mreg[sp_code];
        for (int i = 7; i >= 0; i--) begin
            if (mask[i]) begin
                code = mask_code(i, us);
                v = mreg[code];
                ptr = ptr - 16'd1;
                mmem[ptr[ram_aw-1:0]] = v[7:0]; // low byte first
                if (is_wide(code)) begin
                    ptr = ptr - 16'd1;
                    mmem[ptr[ram_aw-1:0]] = v[15:8];
                end
            end
        end
        mreg[sp_code] = ptr;
    endtask

    task automatic model_pull(logic [7:0] mask, logic us);
        logic [3:0]  sp_code;
        logic [3:0]  code;
        logic [15:0] ptr;
        logic [15:0] v;
        sp_code = us ? reg_u : reg_s;
        ptr = mreg[sp_code];
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                code = mask_code(i, us);
                v = 16'h0000;
                if (is_wide(code)) begin
                    v[15:8] = mmem[ptr[ram_aw-1:0]]; // high byte sits on top
                    ptr = ptr + 16'd1;
                end
                v[7:0] = mmem[ptr[ram_aw-1:0]];
                ptr = ptr + 16'd1;
                mreg[code] = v;
            end
        end
        mreg[sp_code] = ptr;
    endtask

    task automatic model_apply(row_t r, logic [15:0] val);
        case (r.op)
            cmd_load: model_write(r.post[3:0], val);
            cmd_tfr:  model_write(r.post[3:0], model_read(r.post[7:4], 1'b1));
            cmd_push: model_push(r.post, r.ussel);
            default:  model_pull(r.post, r.ussel);
        endcase
    endtask

    // read-back of every code within one low clock phase
    task automatic check_regs(string where);
        logic [3:0]  code;
        logic [15:0] exp;
        for (int c = 0; c < 10; c++) begin
            code = 4'(c);
            rd_sel = reg_code_e'(code);
            #1;
            exp = model_read(code, 1'b0);
            if (rd_data !== exp) begin
                $display("Fail rd_data (%s) %s: got %h, expected %h",
                         names[c], where, rd_data, exp);
                errors++;
            end
        end
    endtask

    task automatic apply_row(int idx);
        row_t        r;
        logic [15:0] val;
        logic        long_op;
        int          n;
        int          exp_n;
        r = table_row(idx);
        val = r.rnd ? 16'($random(seed)) : r.val;
        long_op = (r.op == cmd_push || r.op == cmd_pull) && r.post != 8'h00;
        exp_n = 1;
        if (long_op)
            exp_n = 1 + byte_count(r.post) * (wait_cycles + 2); // pointer cycle plus access
        @(negedge clk);
        cmd_op = r.op;
        cmd_post = r.post;
        cmd_ussel = r.ussel;
        load_data = val;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        n = 1;
        if (busy !== long_op) begin
            $display("Fail busy row %0d: got %h, expected %h", idx, busy, long_op);
            errors++;
        end
        if (r.poke) begin
            // load of a that must be dropped
            cmd_valid = 1'b1;
            cmd_op = cmd_load;
            cmd_post = 8'h00;
            load_data = 16'hdead;
            @(negedge clk);
            cmd_valid = 1'b0;
            cmd_op = r.op;
            cmd_post = r.post;
            load_data = val;
            n = 2;
        end
        while (done !== 1'b1 && n < row_limit) begin
            @(negedge clk);
            n++;
        end
        model_apply(r, val);
        if (done !== 1'b1) begin
            $display("row %0d: done did not come within %0d cycles", idx, row_limit);
            errors++;
        end else begin
            if (n != exp_n) begin
                $display("row %0d: done came after %0d cycles instead of %0d",
                         idx, n, exp_n);
                errors++;
            end
            if (busy !== 1'b0) begin
                $display("Fail busy row %0d: got %h, expected 0", idx, busy);
                errors++;
            end
        end
        @(negedge clk);
        if (done !== 1'b0) begin
            $display("row %0d: done stayed high for more than one cycle", idx);
            errors++;
        end
        check_regs($sformatf("row %0d", idx));
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        seed = 31744;
        errors = 0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = cmd_load;
        cmd_post = 8'h00;
        cmd_ussel = 1'b0;
        load_data = 16'h0000;
        rd_sel = reg_a;
        for (int i = 0; i < 9; i++) begin
            mreg[i] = 16'h0000;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("Fail busy after reset: got %h, expected 0", busy);
            errors++;
        end
        if (done !== 1'b0) begin
            $display("Fail done after reset: got %h, expected 0", done);
            errors++;
        end
        check_regs("after reset");
        for (int i = 0; i < num_rows; i++) begin
            apply_row(i);
        end
        $display("errors: %0d in %0d rows", errors, num_rows);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // worst case push per row plus reset
    initial begin
        #((num_rows * row_limit + 8) * clk_period);
        $display("watchdog: the run did not finish in time");
        $display("errors: %0d in %0d rows", errors, num_rows);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/stack_unit.sv
`timescale 1ns/10ps
`default_nettype none

module stack_unit #(
    parameter int wait_cycles = 2,
    parameter int ram_aw      = 8
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cmd_valid,
    input  wire stack_pkg::cmd_e      cmd_op,
    input  wire stack_pkg::postbyte_u cmd_post,
    input  wire                       cmd_ussel,
    input  wire                [15:0] load_data,
    input  wire stack_pkg::reg_code_e rd_sel,
    output logic               [15:0] rd_data,
    output logic                      busy,
    output logic                      done
);

    logic        load_en;
    logic        tfr_en;
    logic [ 7:0] xfer_bit;
    logic        hihalf;
    logic        ptr_dec;
    logic        ptr_inc;
    logic        mem_we;
    logic        mem_rd;
    logic        pul_we;
    logic        timer_start;
    logic        timer_done;
    logic [15:0] psh_addr;
    logic [ 7:0] psh_byte;
    logic [ 7:0] rd_byte;

    stack_seq stack_seq_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_post    (cmd_post),
        .timer_done  (timer_done),
        .busy        (busy),
        .done        (done),
        .load_en     (load_en),
        .tfr_en      (tfr_en),
        .xfer_bit    (xfer_bit),
        .hihalf      (hihalf),
        .ptr_dec     (ptr_dec),
        .ptr_inc     (ptr_inc),
        .mem_we      (mem_we),
        .mem_rd      (mem_rd),
        .pul_we      (pul_we),
        .timer_start (timer_start)
    );

    // sets how long each stack byte access takes
    access_timer #(
        .wait_cycles (wait_cycles)
    ) access_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_ussel (cmd_ussel),
        .cmd_post  (cmd_post),
        .load_data (load_data),
        .load_en   (load_en),
        .tfr_en    (tfr_en),
        .xfer_bit  (xfer_bit),
        .hihalf    (hihalf),
        .ptr_dec   (ptr_dec),
        .ptr_inc   (ptr_inc),
        .pul_we    (pul_we),
        .rd_byte   (rd_byte),
        .rd_sel    (rd_sel),
        .psh_addr  (psh_addr),
        .psh_byte  (psh_byte),
        .rd_data   (rd_data)
    );

    stack_ram #(
        .ram_aw (ram_aw)
    ) stack_ram_inst (
        .clk   (clk),
        .addr  (psh_addr),
        .we    (mem_we),
        .rd    (mem_rd),
        .wdata (psh_byte),
        .rdata (rd_byte)
    );

endmodule

`default_nettype wire

// File: logic/stack_seq.sv
`timescale 1ns/10ps
`default_nettype none

module stack_seq (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cmd_valid,
    input  wire stack_pkg::cmd_e      cmd_op,
    input  wire stack_pkg::postbyte_u cmd_post,
    input  wire                       timer_done,
    output logic                      busy,
    output logic                      done,
    output logic                      load_en,
    output logic                      tfr_en,
    output logic               [7:0]  xfer_bit,
    output logic                      hihalf,
    output logic                      ptr_dec,
    output logic                      ptr_inc,
    output logic                      mem_we,
    output logic                      mem_rd,
    output logic                      pul_we,
    output logic                      timer_start
);

    import stack_pkg::*;

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_step   = 2'd1; // pointer cycle
    localparam logic [1:0] st_access = 2'd2; // memory access, timed
    localparam logic [1:0] st_finish = 2'd3;

    logic [1:0] state;
    logic [7:0] mask_q;    // registers still to move
    logic       pull_q;
    logic       second_q;  // second byte of a 16-bit register
    logic       accept;
    logic       wide;
    logic       last_byte;
    logic       acc_end;
    logic [7:0] mask_nx;

    // highest set bit as one-hot
    function automatic logic [7:0] top_bit(input logic [7:0] m);
        logic [7:0] r;
        r = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (m[i])
                r = 8'h01 << i;
        end
        return r;
    endfunction

    assign busy   = (state == st_step) || (state == st_access);
    assign done   = (state == st_finish);
    assign accept = cmd_valid && !busy;

    assign load_en = accept && (cmd_op == cmd_load);
    assign tfr_en  = accept && (cmd_op == cmd_tfr);

    // push from the top, pull from the bottom
    assign xfer_bit = pull_q ? (mask_q & (~mask_q + 8'd1)) : top_bit(mask_q);
    assign wide     = xfer_bit[msk_pc] | xfer_bit[msk_sp] | xfer_bit[msk_y] | xfer_bit[msk_x];
    assign last_byte = !wide || second_q;
    assign mask_nx  = mask_q & ~xfer_bit;
    assign hihalf   = second_q ^ pull_q; // push low first, pull high first

    assign acc_end     = (state == st_access) && timer_done;
    assign timer_start = (state == st_step);
    assign ptr_dec     = (state == st_step) && !pull_q;
    assign mem_rd      = (state == st_step) && pull_q;  // read data ready for the access
    assign mem_we      = acc_end && !pull_q;
    assign pul_we      = acc_end && pull_q;
    assign ptr_inc     = acc_end && pull_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            mask_q   <= 8'h00;
            pull_q   <= 1'b0;
            second_q <= 1'b0;
        end else begin
            case (state)
                st_idle, st_finish: begin
                    state <= st_idle;
                    if (accept) begin
                        if ((cmd_op == cmd_push || cmd_op == cmd_pull) &&
                            cmd_post.mask != 8'h00) begin
                            state    <= st_step;
                            mask_q   <= cmd_post.mask;
                            pull_q   <= (cmd_op == cmd_pull);
                            second_q <= 1'b0;
                        end else begin
                            state <= st_finish; // load, tfr and empty mask
                        end
                    end
                end
                st_step: state <= st_access;
                st_access: begin
                    if (timer_done) begin
                        if (!last_byte) begin
                            second_q <= 1'b1;
                            state    <= st_step;
                        end else begin
                            second_q <= 1'b0;
                            mask_q   <= mask_nx;
                            state    <= (mask_nx == 8'h00) ? st_finish : st_step;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cmd_ussel,
    input  wire stack_pkg::postbyte_u cmd_post,
    input  wire             [15:0] load_data,
    input  wire                    load_en,
    input  wire                    tfr_en,
    input  wire             [ 7:0] xfer_bit,
    input  wire                    hihalf,
    input  wire                    ptr_dec,
    input  wire                    ptr_inc,
    input  wire                    pul_we,
    input  wire             [ 7:0] rd_byte,
    input  wire stack_pkg::reg_code_e rd_sel,
    output logic            [15:0] psh_addr,
    output logic            [ 7:0] psh_byte,
    output logic            [15:0] rd_data
);

    import stack_pkg::*;

    logic [ 7:0] a, b, dp, cc;
    logic [15:0] x, y, u, s, pc;
    logic [15:0] sp_other;  // pointer that is not stacked on
    logic [15:0] ptr_nx;
    logic [15:0] tfr_src;
    logic [15:0] wr_val;

    // 8-bit registers get fill in the high byte
    function automatic logic [15:0] reg_read(input logic [3:0] code, input logic fill);
        logic [7:0] hi;
        logic [15:0] r;
        hi = fill ? 8'hff : 8'h00;
        case (code)
            reg_a:   r = {hi, a};
            reg_b:   r = {hi, b};
            reg_x:   r = x;
            reg_y:   r = y;
            reg_s:   r = s;
            reg_u:   r = u;
            reg_dp:  r = {hi, dp};
            reg_cc:  r = {hi, cc};
            reg_pc:  r = pc;
            default: r = 16'h0000;
        endcase
        return r;
    endfunction

    assign psh_addr = cmd_ussel ? u : s;
    assign sp_other = cmd_ussel ? s : u;
    assign ptr_nx   = ptr_inc ? psh_addr + 16'd1 : psh_addr - 16'd1;

    assign tfr_src = reg_read(cmd_post.pair.src, 1'b1);
    assign wr_val  = load_en ? load_data : tfr_src;
    assign rd_data = reg_read(rd_sel, 1'b0); // zero extended on read-back

    // byte going out on a push
    always_comb begin
        case (1'b1)
            xfer_bit[msk_pc]: psh_byte = hihalf ? pc[15:8] : pc[7:0];
            xfer_bit[msk_sp]: psh_byte = hihalf ? sp_other[15:8] : sp_other[7:0];
            xfer_bit[msk_y]:  psh_byte = hihalf ? y[15:8] : y[7:0];
            xfer_bit[msk_x]:  psh_byte = hihalf ? x[15:8] : x[7:0];
            xfer_bit[msk_dp]: psh_byte = dp;
            xfer_bit[msk_b]:  psh_byte = b;
            xfer_bit[msk_a]:  psh_byte = a;
            xfer_bit[msk_cc]: psh_byte = cc;
            default:          psh_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            a  <= 8'h00;
            b  <= 8'h00;
            dp <= 8'h00;
            cc <= 8'h00;
            x  <= 16'h0000;
            y  <= 16'h0000;
            u  <= 16'h0000;
            s  <= 16'h0000;
            pc <= 16'h0000;
        end else begin
            // load and tfr share the destination decode
            if (load_en || tfr_en) begin
                case (cmd_post.pair.dst)
                    reg_a:   a  <= wr_val[7:0];
                    reg_b:   b  <= wr_val[7:0];
                    reg_x:   x  <= wr_val;
                    reg_y:   y  <= wr_val;
                    reg_s:   s  <= wr_val;
                    reg_u:   u  <= wr_val;
                    reg_dp:  dp <= wr_val[7:0];
                    reg_cc:  cc <= wr_val[7:0];
                    reg_pc:  pc <= wr_val;
                    default: ;  // unused codes write nothing
                endcase
            end

            if (ptr_dec || ptr_inc) begin
                if (cmd_ussel)
                    u <= ptr_nx;
                else
                    s <= ptr_nx;
            end

            // pulled byte into its register half
            if (pul_we) begin
                case (1'b1)
                    xfer_bit[msk_pc]: begin
                        if (hihalf) pc[15:8] <= rd_byte;
                        else        pc[7:0]  <= rd_byte;
                    end
                    xfer_bit[msk_sp]: begin
                        if (cmd_ussel) begin
                            if (hihalf) s[15:8] <= rd_byte;
                            else        s[7:0]  <= rd_byte;
                        end else begin
                            if (hihalf) u[15:8] <= rd_byte;
                            else        u[7:0]  <= rd_byte;
                        end
                    end
                    xfer_bit[msk_y]: begin
                        if (hihalf) y[15:8] <= rd_byte;
                        else        y[7:0]  <= rd_byte;
                    end
                    xfer_bit[msk_x]: begin
                        if (hihalf) x[15:8] <= rd_byte;
                        else        x[7:0]  <= rd_byte;
                    end
                    xfer_bit[msk_dp]: dp <= rd_byte;
                    xfer_bit[msk_b]:  b  <= rd_byte;
                    xfer_bit[msk_a]:  a  <= rd_byte;
                    xfer_bit[msk_cc]: cc <= rd_byte;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/stack_ram.sv
`timescale 1ns/10ps
`default_nettype none

module stack_ram #(
    parameter int ram_aw = 8
) (
    input  wire         clk,
    input  wire  [15:0] addr,
    input  wire         we,
    input  wire         rd,
    input  wire  [ 7:0] wdata,
    output logic [ 7:0] rdata
);

    logic [7:0] mem [2**ram_aw];
    logic [ram_aw-1:0] idx;

    assign idx = addr[ram_aw-1:0]; // stack wraps inside the array

    always_ff @(posedge clk) begin
        if (we)
            mem[idx] <= wdata;
        if (rd)
            rdata <= mem[idx];  // held until the next read
    end

endmodule

`default_nettype wire

// File: logic/access_timer.sv
`timescale 1ns/10ps
`default_nettype none

module access_timer #(
    parameter int wait_cycles = 2
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  timer_start,
    output logic timer_done
);

    localparam int cw = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;

    logic [cw-1:0] cnt;
    logic          running;

    // high in the last access cycle only
    assign timer_done = running && (cnt == '0);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (timer_start) begin
            cnt     <= cw'(wait_cycles);
            running <= 1'b1;
        end else if (running) begin
            if (cnt == '0)
                running <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/stack_pkg.sv
`default_nettype none

package stack_pkg;

    // command codes on cmd_op
    typedef enum logic [1:0] {
        cmd_load = 2'd0,
        cmd_tfr  = 2'd1,
        cmd_push = 2'd2,
        cmd_pull = 2'd3
    } cmd_e;

    // register codes as used in the transfer postbyte
    typedef enum logic [3:0] {
        reg_a  = 4'd0,
        reg_b  = 4'd1,
        reg_x  = 4'd2,
        reg_y  = 4'd3,
        reg_s  = 4'd4,
        reg_u  = 4'd5,
        reg_dp = 4'd6,
        reg_cc = 4'd7,
        reg_pc = 4'd8
    } reg_code_e;

    // postbyte seen as a push/pull set or as a tfr pair
    typedef union packed {
        logic [7:0] mask;
        struct packed {
            logic [3:0] src;
            logic [3:0] dst;
        } pair;
    } postbyte_u;

    // mask bit positions, push order is high to low
    localparam int msk_pc = 7;
    localparam int msk_sp = 6; // the other stack pointer
    localparam int msk_y  = 5;
    localparam int msk_x  = 4;
    localparam int msk_dp = 3;
    localparam int msk_b  = 2;
    localparam int msk_a  = 1;
    localparam int msk_cc = 0;

endpackage

`default_nettype wire
